// ==== Makefile ====
# Verilator build of the tb_core testbench around rv_core

SRCS := $(shell grep -v '^+' filelist.f)

.PHONY: run clean

obj_dir/Vtb_core: filelist.f $(SRCS)
	verilator --binary --timing --assert -j 0 -f filelist.f --top-module tb_core -o Vtb_core

# passes only when the pass line appears in the simulator output
run: obj_dir/Vtb_core
	@out="$$(./obj_dir/Vtb_core 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'Finished with no errors'

clean:
	rm -rf obj_dir

// ==== filelist.f ====
hw/rv_pkg.sv
hw/decode_if.sv
hw/rv_fetch.sv
hw/rv_decode.sv
hw/rv_execute.sv
hw/rv_regfile.sv
hw/rv_core.sv
verification/tb_clock.sv
verification/tb_core.sv

// ==== hw/decode_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface decode_if (
  input logic clk
);

  rv_pkg::word_t     pc;
  rv_pkg::word_t     rs1_val;
  rv_pkg::word_t     rs2_val;
  rv_pkg::word_t     imm;
  rv_pkg::reg_addr_t rd;
  rv_pkg::opcode_e   opcode;
  rv_pkg::alu_op_e   alu_op;
  rv_pkg::branch_e   branch;
  // second ALU operand is imm instead of rs2
  logic              use_imm;
  logic              writes_rd;

  modport source (
    input  clk,
    output pc, rs1_val, rs2_val, imm, rd, opcode, alu_op, branch, use_imm, writes_rd
  );

  modport sink (
    input pc, rs1_val, rs2_val, imm, rd, opcode, alu_op, branch, use_imm, writes_rd
  );

endinterface

`default_nettype wire

// ==== hw/rv_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_core (
  input  logic              clk,
  input  logic              rst,
  output logic              wb_cyc,
  output logic              wb_stb,
  output rv_pkg::word_t     wb_adr,
  input  rv_pkg::word_t     wb_dat_i,
  input  logic              wb_ack,
  output logic              halt,
  output logic              retire_valid,
  output rv_pkg::word_t     retire_pc,
  output logic              retire_we,
  output rv_pkg::reg_addr_t retire_rd,
  output rv_pkg::word_t     retire_wdata
);

  rv_pkg::word_t     insn;
  rv_pkg::word_t     pc;
  logic              exec;
  rv_pkg::word_t     next_pc;
  logic              take_halt;
  rv_pkg::reg_addr_t rs1_idx;
  rv_pkg::reg_addr_t rs2_idx;
  rv_pkg::word_t     rs1_data;
  rv_pkg::word_t     rs2_data;
  logic              rd_we;
  rv_pkg::reg_addr_t rd_idx;
  rv_pkg::word_t     rd_wdata;

  decode_if dec_bus (.clk(clk));

  rv_fetch u_fetch (
    .clk(clk), .rst(rst),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_adr(wb_adr), .wb_dat_i(wb_dat_i), .wb_ack(wb_ack),
    .insn(insn), .pc(pc), .exec(exec),
    .next_pc(next_pc), .take_halt(take_halt), .halt(halt)
  );

  rv_decode u_decode (
    .insn(insn), .pc(pc), .exec(exec),
    .rs1_idx(rs1_idx), .rs2_idx(rs2_idx), .rs1_data(rs1_data), .rs2_data(rs2_data),
    .dec(dec_bus.source)
  );

  rv_execute u_execute (
    .dec(dec_bus.sink),
    .next_pc(next_pc), .take_halt(take_halt),
    .rd_we(rd_we), .rd_idx(rd_idx), .rd_wdata(rd_wdata)
  );

  rv_regfile u_regfile (
    .clk(clk), .rst(rst),
    .rs1_idx(rs1_idx), .rs2_idx(rs2_idx), .rs1_data(rs1_data), .rs2_data(rs2_data),
    .we(rd_we), .rd(rd_idx), .wdata(rd_wdata)
  );

  // one retire per exec cycle
  assign retire_valid = exec;
  assign retire_pc    = pc;
  assign retire_we    = rd_we;
  assign retire_rd    = rd_idx;
  assign retire_wdata = rd_wdata;

endmodule

`default_nettype wire

// ==== hw/rv_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_decode (
  input  rv_pkg::word_t     insn,
  input  rv_pkg::word_t     pc,
  input  logic              exec,
  output rv_pkg::reg_addr_t rs1_idx,
  output rv_pkg::reg_addr_t rs2_idx,
  input  rv_pkg::word_t     rs1_data,
  input  rv_pkg::word_t     rs2_data,
  decode_if.source          dec
);

  logic [6:0]        opcode_raw;
  logic [2:0]        funct3;
  logic [6:0]        funct7;
  rv_pkg::reg_addr_t rd;
  rv_pkg::word_t     imm_i;
  rv_pkg::word_t     imm_u;
  rv_pkg::word_t     imm_b;
  rv_pkg::word_t     imm_j;
  rv_pkg::opcode_e   op_d;
  logic              legal;
  logic              wr;

  // funct3 to ALU operation where alt picks sub or sra
  function automatic rv_pkg::alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? rv_pkg::alu_sub : rv_pkg::alu_add;
      3'b001:  return rv_pkg::alu_sll;
      3'b010:  return rv_pkg::alu_slt;
      3'b011:  return rv_pkg::alu_sltu;
      3'b100:  return rv_pkg::alu_xor;
      3'b101:  return alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
      3'b110:  return rv_pkg::alu_or;
      default: return rv_pkg::alu_and;
    endcase
  endfunction

  assign opcode_raw = insn[rv_pkg::opcode_lsb +: 7];
  assign funct3     = insn[rv_pkg::funct3_lsb +: 3];
  assign funct7     = insn[rv_pkg::funct7_lsb +: 7];
  assign rd         = insn[rv_pkg::rd_lsb +: $bits(rv_pkg::reg_addr_t)];
  assign rs1_idx    = insn[rv_pkg::rs1_lsb +: $bits(rv_pkg::reg_addr_t)];
  assign rs2_idx    = insn[rv_pkg::rs2_lsb +: $bits(rv_pkg::reg_addr_t)];

  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_u = {insn[31:12], 12'b0};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};

  always_comb begin
    op_d        = rv_pkg::op_illegal;
    legal       = 1'b1;
    wr          = 1'b0;
    dec.imm     = imm_i;
    dec.use_imm = 1'b1;
    dec.alu_op  = rv_pkg::alu_add;
    dec.branch  = rv_pkg::br_eq;
    case (opcode_raw)
      rv_pkg::op_lui: begin
        op_d       = rv_pkg::op_lui;
        dec.imm    = imm_u;
        dec.alu_op = rv_pkg::alu_pass_b;
        wr         = 1'b1;
      end
      rv_pkg::op_auipc: begin
        op_d    = rv_pkg::op_auipc;
        dec.imm = imm_u;
        wr      = 1'b1;
      end
      rv_pkg::op_jal: begin
        op_d    = rv_pkg::op_jal;
        dec.imm = imm_j;
        wr      = 1'b1;
      end
      rv_pkg::op_jalr: begin
        op_d  = rv_pkg::op_jalr;
        legal = (funct3 == 3'b000);
        wr    = 1'b1;
      end
      rv_pkg::op_branch: begin
        op_d        = rv_pkg::op_branch;
        dec.imm     = imm_b;
        dec.use_imm = 1'b0;
        dec.branch  = rv_pkg::branch_e'(funct3);
        // funct3 010 and 011 are not branches
        legal       = (funct3[2:1] != 2'b01);
      end
      rv_pkg::op_reg_imm: begin
        op_d       = rv_pkg::op_reg_imm;
        wr         = 1'b1;
        dec.alu_op = alu_sel(funct3, funct3 == 3'b101 && funct7 == rv_pkg::funct7_alt);
        if (funct3 == 3'b001) begin
          legal = (funct7 == 7'b0);
        end else if (funct3 == 3'b101) begin
          legal = (funct7 == 7'b0) || (funct7 == rv_pkg::funct7_alt);
        end
      end
      rv_pkg::op_reg_reg: begin
        op_d        = rv_pkg::op_reg_reg;
        dec.use_imm = 1'b0;
        wr          = 1'b1;
        dec.alu_op  = alu_sel(funct3, funct7 == rv_pkg::funct7_alt);
        legal       = (funct7 == 7'b0) ||
                      (funct7 == rv_pkg::funct7_alt && (funct3 == 3'b000 || funct3 == 3'b101));
      end
      rv_pkg::op_system: begin
        // only ecall is kept
        op_d  = rv_pkg::op_system;
        legal = (insn[31:7] == 25'b0);
      end
      rv_pkg::op_load:     op_d = rv_pkg::op_load;
      rv_pkg::op_store:    op_d = rv_pkg::op_store;
      rv_pkg::op_misc_mem: op_d = rv_pkg::op_misc_mem;
      default:             legal = 1'b0;
    endcase
  end

  assign dec.opcode    = legal ? op_d : rv_pkg::op_illegal;
  assign dec.writes_rd = wr && legal && exec && (rd != '0);
  assign dec.pc        = pc;
  assign dec.rs1_val   = rs1_data;
  assign dec.rs2_val   = rs2_data;
  assign dec.rd        = rd;

  a_branch_no_write: assert property (@(posedge dec.clk)
    dec.opcode == rv_pkg::op_branch |-> !dec.writes_rd);

endmodule

`default_nettype wire

// ==== hw/rv_execute.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_execute (
  decode_if.sink            dec,
  output rv_pkg::word_t     next_pc,
  output logic              take_halt,
  output logic              rd_we,
  output rv_pkg::reg_addr_t rd_idx,
  output rv_pkg::word_t     rd_wdata
);

  rv_pkg::word_t a;
  rv_pkg::word_t b;
  rv_pkg::word_t alu_result;
  rv_pkg::word_t pc_seq;
  rv_pkg::word_t pc_imm;
  logic [4:0]    shamt;
  logic          taken;

  assign a      = dec.rs1_val;
  assign b      = dec.use_imm ? dec.imm : dec.rs2_val;
  assign shamt  = b[4:0];
  assign pc_seq = dec.pc + rv_pkg::pc_step;
  // shared by auipc, jal and taken branches
  assign pc_imm = dec.pc + dec.imm;

  always_comb begin
    case (dec.alu_op)
      rv_pkg::alu_add:    alu_result = a + b;
      rv_pkg::alu_sub:    alu_result = a - b;
      rv_pkg::alu_sll:    alu_result = a << shamt;
      rv_pkg::alu_slt:    alu_result = rv_pkg::word_t'($signed(a) < $signed(b));
      rv_pkg::alu_sltu:   alu_result = rv_pkg::word_t'(a < b);
      rv_pkg::alu_xor:    alu_result = a ^ b;
      rv_pkg::alu_srl:    alu_result = a >> shamt;
      rv_pkg::alu_sra:    alu_result = rv_pkg::word_t'($signed(a) >>> shamt);
      rv_pkg::alu_or:     alu_result = a | b;
      rv_pkg::alu_and:    alu_result = a & b;
      rv_pkg::alu_pass_b: alu_result = b;
      default:            alu_result = a + b;
    endcase
  end

  // branch compare always on the two registers
  always_comb begin
    case (dec.branch)
      rv_pkg::br_eq:  taken = (dec.rs1_val == dec.rs2_val);
      rv_pkg::br_ne:  taken = (dec.rs1_val != dec.rs2_val);
      rv_pkg::br_lt:  taken = ($signed(dec.rs1_val) < $signed(dec.rs2_val));
      rv_pkg::br_ge:  taken = ($signed(dec.rs1_val) >= $signed(dec.rs2_val));
      rv_pkg::br_ltu: taken = (dec.rs1_val < dec.rs2_val);
      rv_pkg::br_geu: taken = (dec.rs1_val >= dec.rs2_val);
      default:        taken = 1'b0;
    endcase
  end

  always_comb begin
    next_pc   = pc_seq;
    rd_wdata  = alu_result;
    take_halt = 1'b0;
    case (dec.opcode)
      rv_pkg::op_auipc: rd_wdata = pc_imm;
      rv_pkg::op_jal: begin
        next_pc  = pc_imm;
        rd_wdata = pc_seq;
      end
      rv_pkg::op_jalr: begin
        // target low bit is dropped
        next_pc  = {alu_result[31:1], 1'b0};
        rd_wdata = pc_seq;
      end
      rv_pkg::op_branch: begin
        if (taken) begin
          next_pc = pc_imm;
        end
      end
      rv_pkg::op_system: take_halt = 1'b1;
      default: ;
    endcase
  end

  assign rd_we  = dec.writes_rd;
  assign rd_idx = dec.rd;

endmodule

`default_nettype wire

// ==== hw/rv_fetch.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_fetch (
  input  logic          clk,
  input  logic          rst,
  output logic          wb_cyc,
  output logic          wb_stb,
  output rv_pkg::word_t wb_adr,
  input  rv_pkg::word_t wb_dat_i,
  input  logic          wb_ack,
  output rv_pkg::word_t insn,
  output rv_pkg::word_t pc,
  output logic          exec,
  input  rv_pkg::word_t next_pc,
  input  logic          take_halt,
  output logic          halt
);

  typedef enum logic [1:0] {
    st_fetch,
    st_exec,
    st_halted
  } state_e;

  state_e        state;
  rv_pkg::word_t pc_q;
  rv_pkg::word_t insn_q;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= st_fetch;
      pc_q  <= rv_pkg::reset_pc;
    end else begin
      case (state)
        st_fetch: begin
          if (wb_ack) begin
            state <= st_exec;
          end
        end
        st_exec: begin
          // retire point where pc moves on even when halting
          pc_q  <= next_pc;
          state <= take_halt ? st_halted : st_fetch;
        end
        default: state <= st_halted;
      endcase
    end
  end

  // capture on the ack edge
  always_ff @(posedge clk) begin
    if (state == st_fetch && wb_ack) begin
      insn_q <= wb_dat_i;
    end
  end

  assign wb_cyc = (state == st_fetch);
  assign wb_stb = (state == st_fetch);
  assign wb_adr = pc_q;
  assign insn   = insn_q;
  assign pc     = pc_q;
  assign exec   = (state == st_exec);
  assign halt   = (state == st_halted);

  // next_pc from execute must keep every request word aligned
  a_stb_aligned: assert property (@(posedge clk) disable iff (rst)
    wb_stb |-> wb_adr[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== hw/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

  localparam int xlen = 32;
  localparam int num_regs = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [$clog2(num_regs)-1:0] reg_addr_t;

  localparam word_t pc_step = 32'd4;
  localparam word_t reset_pc = 32'h0000_0000;

  // bit positions of the instruction fields
  localparam int opcode_lsb = 0;
  localparam int rd_lsb = 7;
  localparam int funct3_lsb = 12;
  localparam int rs1_lsb = 15;
  localparam int rs2_lsb = 20;
  localparam int funct7_lsb = 25;

  // selects sub, srai and sra
  localparam logic [6:0] funct7_alt = 7'b0100000;

  // major opcodes, see the base opcode map
  typedef enum logic [6:0] {
    op_illegal  = 7'b0000000,
    op_load     = 7'b0000011,
    op_misc_mem = 7'b0001111,
    op_reg_imm  = 7'b0010011,
    op_auipc    = 7'b0010111,
    op_store    = 7'b0100011,
    op_reg_reg  = 7'b0110011,
    op_lui      = 7'b0110111,
    op_branch   = 7'b1100011,
    op_jalr     = 7'b1100111,
    op_jal      = 7'b1101111,
    op_system   = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b
  } alu_op_e;

  // encoded as the branch funct3
  typedef enum logic [2:0] {
    br_eq  = 3'b000,
    br_ne  = 3'b001,
    br_lt  = 3'b100,
    br_ge  = 3'b101,
    br_ltu = 3'b110,
    br_geu = 3'b111
  } branch_e;

endpackage

`default_nettype wire

// ==== hw/rv_regfile.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_regfile (
  input  logic              clk,
  input  logic              rst,
  input  rv_pkg::reg_addr_t rs1_idx,
  input  rv_pkg::reg_addr_t rs2_idx,
  output rv_pkg::word_t     rs1_data,
  output rv_pkg::word_t     rs2_data,
  input  logic              we,
  input  rv_pkg::reg_addr_t rd,
  input  rv_pkg::word_t     wdata
);

  rv_pkg::word_t regs [rv_pkg::num_regs];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < rv_pkg::num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      // x0 stays at its reset value
      regs[rd] <= wdata;
    end
  end

  // asynchronous read
  assign rs1_data = regs[rs1_idx];
  assign rs2_data = regs[rs2_idx];

  a_x0_rs1_zero: assert property (@(posedge clk) disable iff (rst)
    rs1_idx == '0 |-> rs1_data == '0);

  a_x0_rs2_zero: assert property (@(posedge clk) disable iff (rst)
    rs2_idx == '0 |-> rs2_data == '0);

endmodule

`default_nettype wire

// ==== verification/tb_clock.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clock (
  output logic clk
);

  // 4 ns period
  initial begin
    clk = 1'b0;
  end

  always #2 clk = ~clk;

endmodule

`default_nettype wire

// ==== verification/tb_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_core;

  logic              clk;
  logic              rst;
  logic              wb_cyc;
  logic              wb_stb;
  rv_pkg::word_t     wb_adr;
  rv_pkg::word_t     wb_dat_i;
  logic              wb_ack;
  logic              halt;
  logic              retire_valid;
  rv_pkg::word_t     retire_pc;
  logic              retire_we;
  rv_pkg::reg_addr_t retire_rd;
  rv_pkg::word_t     retire_wdata;

  rv_pkg::word_t imem [256];
  logic [7:0]    load_ptr;
  rv_pkg::word_t model_regs [32];
  rv_pkg::word_t model_pc;
  // {pc, we, rd, wdata} per retired instruction
  logic [69:0]   retire_q [$];
  logic [69:0]   last_trace [$];
  rv_pkg::word_t fetch_q [$];
  string         test_name;
  integer        seed = 32'h06cd9b6f;
  logic          random_waits;
  int            waits_seen;
  logic          ack_prev;
  logic          in_reset;
  logic          delay_set;
  int            waited;
  int            delay;
  rv_pkg::word_t rnd;

  tb_clock u_clock (.clk(clk));

  rv_core u_dut (
    .clk(clk), .rst(rst),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_adr(wb_adr), .wb_dat_i(wb_dat_i), .wb_ack(wb_ack),
    .halt(halt),
    .retire_valid(retire_valid), .retire_pc(retire_pc), .retire_we(retire_we),
    .retire_rd(retire_rd), .retire_wdata(retire_wdata)
  );

  task automatic stop_on_error(input string what);
    $display("Finished with errors");
    $fatal(1, "%s", what);
  endtask

  task automatic check_word(input string field, input rv_pkg::word_t exp,
                            input rv_pkg::word_t act);
    assert (act === exp) else begin
      $display("Fail %s %s: expected %h, actual %h", test_name, field, exp, act);
      stop_on_error("a value differs from the reference model");
    end
  endtask

  // Wishbone slave that acks after 0 to 3 wait states when random_waits is set
  always @(posedge clk) begin
    in_reset = rst;
    #1;
    if (in_reset || wb_ack || !(wb_cyc && wb_stb)) begin
      wb_ack    = 1'b0;
      waited    = 0;
      delay_set = 1'b0;
    end else begin
      if (!delay_set) begin
        rnd       = $random(seed);
        delay     = random_waits ? int'(rnd[1:0]) : 0;
        delay_set = 1'b1;
      end
      if (waited >= delay) begin
        wb_dat_i = imem[wb_adr[9:2]];
        wb_ack   = 1'b1;
      end else begin
        waited++;
        waits_seen++;
      end
    end
  end

  // bus and retire monitor
  always @(negedge clk) begin
    if (rst) begin
      ack_prev = 1'b0;
    end else begin
      assert (!wb_stb || wb_cyc) else stop_on_error("wb_stb was high without wb_cyc");
      assert (retire_valid == ack_prev) else
        stop_on_error("retire_valid did not follow exactly one ack");
      if (wb_ack) begin
        fetch_q.push_back(wb_adr);
      end
      if (retire_valid) begin
        retire_q.push_back({retire_pc, retire_we, retire_rd, retire_wdata});
      end
      ack_prev = wb_ack;
    end
  end

  function automatic rv_pkg::word_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic rv_pkg::word_t enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic rv_pkg::word_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, rv_pkg::op_reg_reg};
  endfunction

  function automatic rv_pkg::word_t enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_pkg::op_branch};
  endfunction

  function automatic rv_pkg::word_t enc_j(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, rv_pkg::op_jal};
  endfunction

  // RV32I integer rules where alt selects sub or sra
  function automatic rv_pkg::word_t alu_ref(input logic [2:0] f3, input logic alt,
                                            input rv_pkg::word_t x, input rv_pkg::word_t y);
    logic signed [31:0] sx;
    logic signed [31:0] sy;
    sx = x;
    sy = y;
    case (f3)
      3'd0:    return alt ? x - y : x + y;
      3'd1:    return x << y[4:0];
      3'd2:    return {31'b0, sx < sy};
      3'd3:    return {31'b0, x < y};
      3'd4:    return x ^ y;
      3'd5: begin
        if (alt) begin
          return sx >>> y[4:0];
        end
        return x >> y[4:0];
      end
      3'd6:    return x | y;
      default: return x & y;
    endcase
  endfunction

  // one architectural step of the reference model at model_pc
  task automatic model_step(input rv_pkg::word_t insn, output logic we,
                            output rv_pkg::reg_addr_t rd, output rv_pkg::word_t wdata,
                            output rv_pkg::word_t npc, output logic stop);
    rv_pkg::word_t x;
    rv_pkg::word_t y;
    rv_pkg::word_t imm_i;
    rv_pkg::word_t imm_b;
    rv_pkg::word_t imm_j;
    logic [2:0]    f3;
    logic          taken;
    x     = model_regs[insn[19:15]];
    y     = model_regs[insn[24:20]];
    imm_i = {{20{insn[31]}}, insn[31:20]};
    imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
    imm_j = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
    f3    = insn[14:12];
    rd    = insn[11:7];
    we    = 1'b0;
    wdata = '0;
    npc   = model_pc + 32'd4;
    stop  = 1'b0;
    taken = 1'b0;
    case (insn[6:0])
      rv_pkg::op_lui: begin
        we    = 1'b1;
        wdata = {insn[31:12], 12'b0};
      end
      rv_pkg::op_auipc: begin
        we    = 1'b1;
        wdata = model_pc + {insn[31:12], 12'b0};
      end
      rv_pkg::op_jal: begin
        we    = 1'b1;
        wdata = model_pc + 32'd4;
        npc   = model_pc + imm_j;
      end
      rv_pkg::op_jalr: begin
        we    = 1'b1;
        wdata = model_pc + 32'd4;
        npc   = (x + imm_i) & ~32'd1;
      end
      rv_pkg::op_branch: begin
        case (f3)
          3'd0:    taken = (x == y);
          3'd1:    taken = (x != y);
          3'd4:    taken = ($signed(x) < $signed(y));
          3'd5:    taken = ($signed(x) >= $signed(y));
          3'd6:    taken = (x < y);
          3'd7:    taken = (x >= y);
          default: taken = 1'b0;
        endcase
        if (taken) begin
          npc = model_pc + imm_b;
        end
      end
      rv_pkg::op_reg_imm: begin
        we    = 1'b1;
        wdata = alu_ref(f3, f3 == 3'd5 && insn[30], x, imm_i);
      end
      rv_pkg::op_reg_reg: begin
        we    = 1'b1;
        wdata = alu_ref(f3, insn[30], x, y);
      end
      rv_pkg::op_system: stop = 1'b1;
      default: ;
    endcase
    if (rd == 5'd0) begin
      we = 1'b0;
    end
  endtask

  // unused words decode as loads, which the core skips
  task automatic clear_program();
    for (int i = 0; i < 256; i++) begin
      imem[i[7:0]] = {i[24:0], 7'b0000011};
    end
    load_ptr = 8'd0;
  endtask

  task automatic emit(input rv_pkg::word_t w);
    imem[load_ptr] = w;
    load_ptr = load_ptr + 8'd1;
  endtask

  task automatic emit_addi(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
    emit(enc_i(imm, rs1, 3'd0, rd, rv_pkg::op_reg_imm));
  endtask

  task automatic load_const(input logic [4:0] rd, input rv_pkg::word_t value);
    rv_pkg::word_t upper;
    // addi sign extends, so bit 11 carries into the upper part
    upper = value + 32'h0000_0800;
    emit(enc_u(upper[31:12], rd, rv_pkg::op_lui));
    emit_addi(rd, rd, value[11:0]);
  endtask

  task automatic emit_branch_skip(input logic [2:0] f3, input logic [4:0] rs1,
                                  input logic [4:0] rs2);
    emit(enc_b(13'd8, rs2, rs1, f3));
    emit_addi(5'd3, 5'd3, 12'd1);
  endtask

  task automatic reset_core();
    @(posedge clk);
    #1;
    rst = 1'b1;
    retire_q.delete();
    fetch_q.delete();
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    check_word("halt after reset", 32'd0, {31'b0, halt});
    check_word("retire_valid after reset", 32'd0, {31'b0, retire_valid});
    assert (wb_cyc && wb_stb) else stop_on_error("no fetch request right after reset");
    check_word("first request address", rv_pkg::reset_pc, wb_adr);
  endtask

  // runs imem from reset to ecall and checks every retire against the model
  task automatic run_program(input string name);
    logic [69:0]       entry;
    logic              m_we;
    rv_pkg::reg_addr_t m_rd;
    rv_pkg::word_t     m_wdata;
    rv_pkg::word_t     m_npc;
    logic              m_stop;
    int                guard;
    int                count;
    test_name = name;
    reset_core();
    for (int i = 0; i < 32; i++) begin
      model_regs[i[4:0]] = '0;
    end
    model_pc = rv_pkg::reset_pc;
    last_trace.delete();
    m_stop = 1'b0;
    count  = 0;
    while (!m_stop) begin
      guard = 0;
      while (retire_q.size() == 0) begin
        @(posedge clk);
        guard++;
        if (guard > 100) stop_on_error("no instruction retired within 100 cycles");
      end
      entry = retire_q.pop_front();
      assert (fetch_q.size() != 0) else stop_on_error("an instruction retired without a fetch");
      check_word("fetch address", model_pc, fetch_q.pop_front());
      model_step(imem[model_pc[9:2]], m_we, m_rd, m_wdata, m_npc, m_stop);
      check_word("retire pc", model_pc, entry[69:38]);
      check_word("retire we", {31'b0, m_we}, {31'b0, entry[37]});
      if (m_we) begin
        check_word("retire rd", {27'b0, m_rd}, {27'b0, entry[36:32]});
        check_word("retire wdata", m_wdata, entry[31:0]);
        model_regs[m_rd] = m_wdata;
      end
      last_trace.push_back(entry);
      model_pc = m_npc;
      count++;
      if (count > 300) stop_on_error("the program never reached ecall");
    end
    guard = 0;
    @(negedge clk);
    while (!halt) begin
      guard++;
      if (guard > 4) stop_on_error("halt did not rise after ecall");
      @(negedge clk);
    end
    repeat (50) begin
      @(negedge clk);
      assert (halt && !wb_cyc && !retire_valid) else
        stop_on_error("the core left the halted state");
    end
    assert (retire_q.size() == 0) else stop_on_error("an instruction retired after ecall");
  endtask

  task automatic test_reset();
    clear_program();
    emit(32'h0000_0073);
    run_program("reset");
  endtask

  task automatic test_reg_imm();
    clear_program();
    emit_addi(5'd1, 5'd0, 12'd100);
    emit_addi(5'd2, 5'd1, -12'd7);
    emit(enc_i(12'd200, 5'd2, 3'd2, 5'd3, rv_pkg::op_reg_imm));
    emit(enc_i(-12'd1, 5'd2, 3'd3, 5'd4, rv_pkg::op_reg_imm));
    emit(enc_i(12'h0f0, 5'd1, 3'd4, 5'd5, rv_pkg::op_reg_imm));
    emit(enc_i(-12'd256, 5'd1, 3'd6, 5'd6, rv_pkg::op_reg_imm));
    emit(enc_i(12'h7ff, 5'd6, 3'd7, 5'd7, rv_pkg::op_reg_imm));
    emit(enc_i(12'd27, 5'd1, 3'd1, 5'd8, rv_pkg::op_reg_imm));
    emit(enc_i(12'd3, 5'd8, 3'd5, 5'd9, rv_pkg::op_reg_imm));
    // srai
    emit(enc_i(12'h403, 5'd8, 3'd5, 5'd10, rv_pkg::op_reg_imm));
    emit_addi(5'd0, 5'd1, 12'd5);
    emit(enc_u(20'habcde, 5'd11, rv_pkg::op_lui));
    emit(enc_u(20'h12345, 5'd12, rv_pkg::op_auipc));
    // a load is dropped and falls through
    emit(enc_i(12'd0, 5'd1, 3'd2, 5'd13, rv_pkg::op_load));
    emit(32'h0000_0073);
    run_program("reg_imm");
  endtask

  task automatic test_reg_reg();
    rv_pkg::word_t a;
    rv_pkg::word_t b;
    clear_program();
    for (int r = 0; r < 3; r++) begin
      a = $random(seed);
      b = $random(seed);
      // opposite signs make signed and unsigned compares disagree
      b[31] = ~a[31];
      load_const(5'd1, a);
      load_const(5'd2, b);
      for (int f = 0; f < 8; f++) begin
        emit(enc_r(7'h00, 5'd2, 5'd1, f[2:0], f[4:0] + 5'd3));
      end
      emit(enc_r(rv_pkg::funct7_alt, 5'd2, 5'd1, 3'd0, 5'd11));
      emit(enc_r(rv_pkg::funct7_alt, 5'd2, 5'd1, 3'd5, 5'd12));
      emit(enc_r(7'h00, 5'd1, 5'd2, 3'd2, 5'd13));
      emit(enc_r(7'h00, 5'd1, 5'd2, 3'd3, 5'd14));
    end
    emit(32'h0000_0073);
    run_program("reg_reg");
  endtask

  task automatic build_control_program();
    clear_program();
    emit_addi(5'd1, 5'd0, 12'd5);
    emit_addi(5'd2, 5'd0, -12'd3);
    // every branch kind on three operand orders where each skips one addi when taken
    for (int k = 0; k < 8; k++) begin
      if (k[2:1] != 2'b01) begin
        emit_branch_skip(k[2:0], 5'd1, 5'd2);
        emit_branch_skip(k[2:0], 5'd2, 5'd1);
        emit_branch_skip(k[2:0], 5'd1, 5'd1);
      end
    end
    emit(enc_j(21'd12, 5'd5));
    emit_addi(5'd3, 5'd3, 12'd1);
    emit_addi(5'd3, 5'd3, 12'd1);
    // odd jalr target lands two words past the jalr
    emit(enc_u(20'h00000, 5'd6, rv_pkg::op_auipc));
    emit_addi(5'd6, 5'd6, 12'd17);
    emit(enc_i(12'd0, 5'd6, 3'd0, 5'd7, rv_pkg::op_jalr));
    emit_addi(5'd3, 5'd3, 12'd1);
    // backward loop of five passes
    emit_addi(5'd8, 5'd8, 12'd1);
    emit(enc_b(-13'd4, 5'd1, 5'd8, 3'd4));
    emit(32'h0000_0073);
  endtask

  task automatic test_control_flow();
    build_control_program();
    run_program("control_flow");
  endtask

  task automatic test_wait_states();
    logic [69:0] saved [$];
    saved        = last_trace;
    random_waits = 1'b1;
    waits_seen   = 0;
    build_control_program();
    run_program("wait_states");
    random_waits = 1'b0;
    assert (waits_seen > 0) else stop_on_error("no wait states were inserted");
    assert (last_trace.size() == saved.size()) else
      stop_on_error("the retire count changed under wait states");
    for (int i = 0; i < saved.size(); i++) begin
      assert (last_trace[i] === saved[i]) else begin
        $display("Fail %s retire %0d: expected %h, actual %h", test_name, i, saved[i],
                 last_trace[i]);
        stop_on_error("the retire sequence changed under wait states");
      end
    end
  endtask

  task automatic test_ecall();
    clear_program();
    emit_addi(5'd1, 5'd0, 12'd1);
    emit(32'h0000_0073);
    emit_addi(5'd2, 5'd0, 12'd2);
    run_program("ecall");
  endtask

  initial begin
    rst          = 1'b1;
    wb_ack       = 1'b0;
    wb_dat_i     = '0;
    random_waits = 1'b0;
    waits_seen   = 0;
    ack_prev     = 1'b0;
    delay_set    = 1'b0;
    waited       = 0;
    delay        = 0;
    test_reset();
    test_reg_imm();
    test_reg_reg();
    test_control_flow();
    test_wait_states();
    test_ecall();
    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire
